// File: run.sh
#!/bin/sh
# compile and run the tracker testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_rv_pipe_tracker -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// rv32i major opcodes, as the spec lists them
localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_AUIPC  = 7'b0010111;
localparam logic [6:0] OP_JAL    = 7'b1101111;
localparam logic [6:0] OP_JALR   = 7'b1100111;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;
localparam logic [6:0] OP_STORE  = 7'b0100011;
localparam logic [6:0] OP_IMM    = 7'b0010011;
localparam logic [6:0] OP_REG    = 7'b0110011;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

// b offset is 13 bits, bit 0 is implied
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

// j offset is 21 bits, bit 0 is implied
function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

`endif

// File: sim/tb_rv_pipe_tracker.sv
`timescale 1ns/1ps

module tb_rv_pipe_tracker;

    `include "tb_encode.svh"

    localparam int NS = 5;
    localparam int TEST_CYCLES = 600;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] gold;
        logic [31:0] next_pc;
        logic        legal;
        logic        gold_v;
        logic        ctrl;
    } trace_ent_t;

    logic          clk;
    logic          rst;
    logic          fetch_valid_i;
    logic [31:0]   fetch_inst_i;
    logic [31:0]   fetch_pc_i;
    logic [NS-1:0] stall_i;
    logic [NS-1:0] flush_i;
    logic          retire_valid_o;
    logic [31:0]   retire_pc_o;
    logic [31:0]   retire_inst_o;
    logic          retire_illegal_o;
    logic          gold_valid_o;
    logic [31:0]   gold_result_o;
    logic          pc_error_o;

    // reference pipeline with the capture register in slot 0
    trace_ent_t drv_ent;
    trace_ent_t m_ent [NS+1];
    logic       m_valid [NS+1];
    trace_ent_t exp_ent;
    logic       exp_valid;
    logic       exp_pcerr;
    logic       armed;
    logic [31:0] exp_pc;
    logic [31:0] stim_pc;
    int n_retired;
    int n_pc_err;
    int n_gold;

    rv_pipe_tracker #(.NUM_STAGES(NS)) DUT (
        .clk              (clk),
        .rst              (rst),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_pc_i       (fetch_pc_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_inst_o    (retire_inst_o),
        .retire_illegal_o (retire_illegal_o),
        .gold_valid_o     (gold_valid_o),
        .gold_result_o    (gold_result_o),
        .pc_error_o       (pc_error_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // builds one instruction of the given kind with its expected results
    function automatic trace_ent_t make_entry(input int sel, input logic [31:0] pc);
        trace_ent_t e;
        logic [31:0] r;
        logic [20:0] joff;
        logic [12:0] boff;
        r = $urandom;
        joff = {{11{r[9]}}, r[9:2], 2'b00};
        boff = {{5{r[7]}}, r[7:2], 2'b00};
        e.pc = pc;
        e.legal = 1'b1;
        e.gold_v = 1'b0;
        e.gold = 32'd0;
        e.ctrl = 1'b0;
        e.next_pc = pc + 32'd4;
        case (sel)
            0: e.inst = enc_r(7'h00, r[24:20], r[19:15], 3'b000, r[11:7]);
            1: e.inst = enc_r(7'h20, r[24:20], r[19:15], 3'b101, r[11:7]);
            2: begin
                // m-extension funct7 is not rv32i
                e.inst = enc_r(7'h01, r[24:20], r[19:15], 3'b000, r[11:7]);
                e.legal = 1'b0;
            end
            3: e.inst = enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OP_IMM);
            4: e.inst = enc_i(r[31:20], r[19:15], 3'b010, r[11:7], OP_LOAD);
            5: begin
                e.inst = enc_i(r[31:20], r[19:15], 3'b011, r[11:7], OP_LOAD);
                e.legal = 1'b0;
            end
            6: e.inst = enc_s(r[31:20], r[24:20], r[19:15], 3'b010);
            7: e.inst = enc_u(r[31:12], r[11:7], OP_LUI);
            8: begin
                e.inst = enc_u(r[31:12], r[11:7], OP_AUIPC);
                e.gold_v = 1'b1;
                e.gold = pc + {r[31:12], 12'h000};
            end
            9: begin
                e.inst = enc_j(joff, r[14:10]);
                e.gold_v = 1'b1;
                e.gold = pc + 32'd4;
                e.next_pc = pc + {{11{joff[20]}}, joff};
            end
            10: begin
                // offset bit 1 set so the target is not word aligned
                joff[1] = 1'b1;
                e.inst = enc_j(joff, r[14:10]);
                e.legal = 1'b0;
                e.next_pc = pc + {{11{joff[20]}}, joff};
            end
            11: begin
                e.inst = enc_b(boff, r[24:20], r[19:15], 3'b000);
                e.ctrl = 1'b1;
            end
            12: begin
                e.inst = enc_i({r[31:22], 2'b00}, r[19:15], 3'b000, r[11:7], OP_JALR);
                e.ctrl = 1'b1;
            end
            13: e.inst = 32'h0000_0073;
            default: e.inst = 32'h0ff0_000f;
        endcase
        return e;
    endfunction

    // one clock of stimulus with no fetch for a negative sel
    task automatic drive_step(input logic [NS-1:0] st, input logic [NS-1:0] fl,
                              input int sel, input logic wrong);
        trace_ent_t e;
        logic take;
        @(posedge clk);
        take = (sel >= 0) && !st[0] && !fl[0];
        e = make_entry((sel < 0) ? 0 : sel, stim_pc);
        stall_i <= st;
        flush_i <= fl;
        fetch_valid_i <= take;
        fetch_inst_i <= e.inst;
        fetch_pc_i <= e.pc;
        drv_ent <= e;
        if (take) begin
            stim_pc = e.next_pc + (wrong ? 32'd8 : 32'd0);
        end
    endtask

    always @(posedge clk) begin
        logic [NS-1:0] prev_st;
        if (rst) begin
            for (int k = 0; k <= NS; k++) begin
                m_valid[k] = 1'b0;
            end
            exp_valid <= 1'b0;
            exp_pcerr <= 1'b0;
            armed <= 1'b0;
        end else begin
            prev_st = {stall_i[NS-2:0], stall_i[0]};
            exp_valid <= m_valid[NS];
            exp_ent <= m_ent[NS];
            exp_pcerr <= m_valid[NS] && armed && (m_ent[NS].pc != exp_pc);
            if (m_valid[NS]) begin
                armed <= !m_ent[NS].ctrl;
                exp_pc <= m_ent[NS].next_pc;
                n_retired++;
                if (armed && (m_ent[NS].pc != exp_pc)) begin
                    n_pc_err++;
                end
                if (m_ent[NS].gold_v) begin
                    n_gold++;
                end
            end
            // walk from the back so each slot reads its old predecessor
            for (int k = NS - 1; k >= 0; k--) begin
                if (flush_i[k]) begin
                    m_valid[k+1] = 1'b0;
                end else if (!stall_i[k]) begin
                    m_valid[k+1] = m_valid[k] && !prev_st[k];
                    m_ent[k+1] = m_ent[k];
                end
            end
            if (flush_i[0]) begin
                m_valid[0] = 1'b0;
            end else if (!stall_i[0]) begin
                m_valid[0] = fetch_valid_i;
                if (fetch_valid_i) begin
                    m_ent[0] = drv_ent;
                end
            end
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) retire_valid_o == exp_valid)
        else report_mismatch("retire_valid_o", 32'($sampled(retire_valid_o)),
                             32'($sampled(exp_valid)));
    a_pc: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> retire_pc_o == exp_ent.pc)
        else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(exp_ent.pc));
    a_inst: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> retire_inst_o == exp_ent.inst)
        else report_mismatch("retire_inst_o", $sampled(retire_inst_o),
                             $sampled(exp_ent.inst));
    a_illegal: assert property (@(posedge clk) disable iff (rst)
        retire_illegal_o == (exp_valid && !exp_ent.legal))
        else report_mismatch("retire_illegal_o", 32'($sampled(retire_illegal_o)),
                             32'($sampled(exp_valid) && !$sampled(exp_ent.legal)));
    a_gold_v: assert property (@(posedge clk) disable iff (rst)
        gold_valid_o == (exp_valid && exp_ent.gold_v))
        else report_mismatch("gold_valid_o", 32'($sampled(gold_valid_o)),
                             32'($sampled(exp_valid) && $sampled(exp_ent.gold_v)));
    a_gold: assert property (@(posedge clk) disable iff (rst)
        (exp_valid && exp_ent.gold_v) |-> gold_result_o == exp_ent.gold)
        else report_mismatch("gold_result_o", $sampled(gold_result_o),
                             $sampled(exp_ent.gold));
    a_pcerr: assert property (@(posedge clk) disable iff (rst) pc_error_o == exp_pcerr)
        else report_mismatch("pc_error_o", 32'($sampled(pc_error_o)),
                             32'($sampled(exp_pcerr)));

    initial begin
        #(20 * (TEST_CYCLES * 2 + 100));
        fail_run("timeout, the test did not finish in time");
    end

    initial begin
        int straight [7] = '{0, 1, 3, 4, 6, 7, 8};
        logic [31:0] r;
        logic [NS-1:0] st;
        logic [NS-1:0] fl;
        int depth;
        void'($urandom(32'h814e));
        n_retired = 0;
        n_pc_err = 0;
        n_gold = 0;
        stim_pc = 32'h0000_1000;
        rst = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_inst_i = '0;
        fetch_pc_i = '0;
        stall_i = '0;
        flush_i = '0;
        drv_ent = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // straight line code without stalls
        repeat (40) drive_step('0, '0, straight[$urandom_range(0, 6)], 1'b0);
        // random mix of legal and illegal words
        repeat (200) drive_step('0, '0, $urandom_range(0, 14), 1'b0);

        // jal to its target and then wrong pcs after a non-branch and a jal
        drive_step('0, '0, 9, 1'b0);
        drive_step('0, '0, 3, 1'b0);
        drive_step('0, '0, 3, 1'b1);
        drive_step('0, '0, 0, 1'b0);
        drive_step('0, '0, 9, 1'b1);
        repeat (7) drive_step('0, '0, 3, 1'b0);

        // monotone stalls and single stage flushes
        repeat (300) begin
            r = $urandom;
            depth = (r[1:0] == 2'b00) ? int'(r[4:2]) % (NS + 1) : 0;
            st = '0;
            for (int k = 0; k < depth; k++) begin
                st[k] = 1'b1;
            end
            fl = '0;
            if (r[7:5] == 3'b000) begin
                fl[int'(r[10:8]) % NS] = 1'b1;
            end
            drive_step(st, fl, $urandom_range(0, 14), r[15:11] == 5'd0);
        end

        repeat (NS + 15) drive_step('0, '0, -1, 1'b0);
        @(posedge clk);

        if (n_retired == 0 || n_pc_err == 0 || n_gold == 0) begin
            fail_run("stimulus did not reach retirement, pc errors and golden values");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: source/fetch_capture.sv
`timescale 1ns/1ps

module fetch_capture (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid_i,
    input  logic [rv_trace_pkg::ILEN-1:0]    fetch_inst_i,
    input  logic [rv_trace_pkg::XLEN-1:0]    fetch_pc_i,
    input  logic                             stall_i,
    input  logic                             flush_i,
    output logic [rv_trace_pkg::ILEN-1:0]    inst_o,
    output logic [rv_trace_pkg::XLEN-1:0]    pc_o,
    output logic                             legal_o,
    output logic                             bubble_o
);

    rv_trace_pkg::rv_word_u word;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       fence_ok;
    logic       fence_i_ok;
    logic       system_ok;
    logic       legal;

    assign word = fetch_inst_i;
    assign funct7 = fetch_inst_i[31:25];
    assign funct3 = word.i.funct3;

    // fence: fm must be zero, pred/succ free, rs1 and rd zero
    assign fence_ok = (fetch_inst_i[31:28] == 4'b0000) &&
                      (word.i.rs1 == 5'd0) &&
                      (funct3 == rv_trace_pkg::F3_FENCE) &&
                      (word.i.rd == 5'd0);

    // fence.i: whole immediate zero
    assign fence_i_ok = (word.i.imm12 == 12'd0) &&
                        (word.i.rs1 == 5'd0) &&
                        (funct3 == rv_trace_pkg::F3_FENCE_I) &&
                        (word.i.rd == 5'd0);

    // ecall or ebreak, only imm bit 0 may differ
    assign system_ok = (word.i.imm12[11:1] == 11'd0) && (fetch_inst_i[19:7] == 13'd0);

    always_comb begin
        legal = 1'b0;
        case (word.i.opcode)
            rv_trace_pkg::OPC_LUI,
            rv_trace_pkg::OPC_AUIPC: begin
                legal = 1'b1;
            end
            rv_trace_pkg::OPC_JAL: begin
                // target must stay word aligned
                legal = (word.j.imm10_1[0] == 1'b0);
            end
            rv_trace_pkg::OPC_JALR: begin
                legal = (funct3 == 3'b000) && (word.i.imm12[1:0] == 2'b00);
            end
            rv_trace_pkg::OPC_BRANCH: begin
                // inst[8] is imm bit 1 of the b-type offset
                legal = (funct3 inside {rv_trace_pkg::F3_BEQ, rv_trace_pkg::F3_BNE,
                                        rv_trace_pkg::F3_BLT, rv_trace_pkg::F3_BGE,
                                        rv_trace_pkg::F3_BLTU, rv_trace_pkg::F3_BGEU}) &&
                        !fetch_inst_i[8];
            end
            rv_trace_pkg::OPC_LOAD: begin
                legal = funct3 inside {rv_trace_pkg::F3_LB, rv_trace_pkg::F3_LH,
                                       rv_trace_pkg::F3_LW, rv_trace_pkg::F3_LBU,
                                       rv_trace_pkg::F3_LHU};
            end
            rv_trace_pkg::OPC_STORE: begin
                legal = funct3 inside {rv_trace_pkg::F3_SB, rv_trace_pkg::F3_SH,
                                       rv_trace_pkg::F3_SW};
            end
            rv_trace_pkg::OPC_OP_IMM: begin
                // only the shifts constrain the upper immediate
                if (funct3 == rv_trace_pkg::F3_SLL) begin
                    legal = (funct7 == rv_trace_pkg::FUNCT7_BASE);
                end else if (funct3 == rv_trace_pkg::F3_SR) begin
                    legal = (funct7 == rv_trace_pkg::FUNCT7_BASE) ||
                            (funct7 == rv_trace_pkg::FUNCT7_ALT);
                end else begin
                    legal = 1'b1;
                end
            end
            rv_trace_pkg::OPC_OP: begin
                // alt funct7 only for sub and sra
                legal = (funct7 == rv_trace_pkg::FUNCT7_BASE) ||
                        ((funct7 == rv_trace_pkg::FUNCT7_ALT) &&
                         ((funct3 == rv_trace_pkg::F3_ADD) || (funct3 == rv_trace_pkg::F3_SR)));
            end
            rv_trace_pkg::OPC_MISC_MEM: begin
                legal = fence_ok || fence_i_ok;
            end
            rv_trace_pkg::OPC_SYSTEM: begin
                legal = system_ok;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // capture register, held while stage 0 is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_o   <= rv_trace_pkg::NOP_INST;
            pc_o     <= rv_trace_pkg::PC_INIT;
            legal_o  <= 1'b1;
            bubble_o <= 1'b1;
        end else if (flush_i) begin
            bubble_o <= 1'b1;
        end else if (!stall_i) begin
            if (fetch_valid_i) begin
                inst_o  <= fetch_inst_i;
                pc_o    <= fetch_pc_i;
                legal_o <= legal;
            end
            bubble_o <= !fetch_valid_i;
        end
    end

endmodule

// File: source/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             stall_i,
    input  logic                             prev_stall_i,
    input  logic                             flush_i,
    input  logic [rv_trace_pkg::ILEN-1:0]    inst_i,
    input  logic [rv_trace_pkg::XLEN-1:0]    pc_i,
    input  logic                             legal_i,
    input  logic                             bubble_i,
    output logic [rv_trace_pkg::ILEN-1:0]    inst_o,
    output logic [rv_trace_pkg::XLEN-1:0]    pc_o,
    output logic                             legal_o,
    output logic                             bubble_o
);

    logic take_bubble;

    // predecessor held its entry, so this slot must not duplicate it
    assign take_bubble = bubble_i || prev_stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_o   <= rv_trace_pkg::NOP_INST;
            pc_o     <= rv_trace_pkg::PC_INIT;
            legal_o  <= 1'b1;
            bubble_o <= 1'b1;
        end else if (flush_i) begin
            // payload is left as is, only the bubble flag matters
            bubble_o <= 1'b1;
        end else if (!stall_i) begin
            inst_o   <= inst_i;
            pc_o     <= pc_i;
            legal_o  <= legal_i;
            bubble_o <= take_bubble;
        end
    end

endmodule

// File: source/retire_check.sv
`timescale 1ns/1ps

module retire_check (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [rv_trace_pkg::ILEN-1:0]    inst_i,
    input  logic [rv_trace_pkg::XLEN-1:0]    pc_i,
    input  logic                             legal_i,
    input  logic                             bubble_i,
    output logic                             retire_valid_o,
    output logic [rv_trace_pkg::XLEN-1:0]    retire_pc_o,
    output logic [rv_trace_pkg::ILEN-1:0]    retire_inst_o,
    output logic                             retire_illegal_o,
    output logic                             gold_valid_o,
    output logic [rv_trace_pkg::XLEN-1:0]    gold_result_o,
    output logic                             pc_error_o
);

    rv_trace_pkg::rv_word_u word;
    logic                          retiring;
    logic                          is_auipc;
    logic                          is_jal;
    logic                          is_ctrl;
    logic [rv_trace_pkg::XLEN-1:0] pc_plus4;
    logic [rv_trace_pkg::XLEN-1:0] auipc_sum;
    logic [rv_trace_pkg::XLEN-1:0] jal_offset;
    logic [rv_trace_pkg::XLEN-1:0] jal_target;
    logic [rv_trace_pkg::XLEN-1:0] gold_next;

    // next-pc expectation
    logic                          exp_armed;
    logic [rv_trace_pkg::XLEN-1:0] exp_pc;

    assign word = inst_i;
    assign retiring = !bubble_i;

    assign is_auipc = (word.u.opcode == rv_trace_pkg::OPC_AUIPC);
    assign is_jal = (word.j.opcode == rv_trace_pkg::OPC_JAL);
    assign is_ctrl = (word.u.opcode == rv_trace_pkg::OPC_JALR) ||
                     (word.u.opcode == rv_trace_pkg::OPC_BRANCH);

    assign pc_plus4 = pc_i + 32'd4;
    assign auipc_sum = pc_i + {word.u.uimm20, 12'h000};

    // j immediate, reassembled and sign extended
    assign jal_offset = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                         word.j.imm11, word.j.imm10_1, 1'b0};
    assign jal_target = pc_i + jal_offset;

    assign gold_next = is_auipc ? auipc_sum : pc_plus4;

    // retire strobe and status flags
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o   <= 1'b0;
            retire_illegal_o <= 1'b0;
            gold_valid_o     <= 1'b0;
        end else begin
            retire_valid_o   <= retiring;
            retire_illegal_o <= retiring && !legal_i;
            gold_valid_o     <= retiring && legal_i && (is_auipc || is_jal);
        end
    end

    // retire payload
    always_ff @(posedge clk) begin
        retire_pc_o   <= pc_i;
        retire_inst_o <= inst_i;
        gold_result_o <= gold_next;
    end

    // compare against the armed expectation, then re-arm from this one
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_armed  <= 1'b0;
            pc_error_o <= 1'b0;
        end else begin
            pc_error_o <= retiring && exp_armed && (pc_i != exp_pc);
            if (retiring) begin
                // branch and jalr targets depend on register values
                exp_armed <= !is_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retiring) begin
            exp_pc <= is_jal ? jal_target : pc_plus4;
        end
    end

endmodule

// File: source/rv_pipe_tracker.sv
`timescale 1ns/1ps

module rv_pipe_tracker #(
    parameter int NUM_STAGES = 5
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid_i,
    input  logic [rv_trace_pkg::ILEN-1:0]    fetch_inst_i,
    input  logic [rv_trace_pkg::XLEN-1:0]    fetch_pc_i,
    input  logic [NUM_STAGES-1:0]            stall_i,
    input  logic [NUM_STAGES-1:0]            flush_i,
    output logic                             retire_valid_o,
    output logic [rv_trace_pkg::XLEN-1:0]    retire_pc_o,
    output logic [rv_trace_pkg::ILEN-1:0]    retire_inst_o,
    output logic                             retire_illegal_o,
    output logic                             gold_valid_o,
    output logic [rv_trace_pkg::XLEN-1:0]    gold_result_o,
    output logic                             pc_error_o
);

    // entry 0 is the capture register, entry k+1 is stage k
    logic [rv_trace_pkg::ILEN-1:0] chain_inst   [NUM_STAGES+1];
    logic [rv_trace_pkg::XLEN-1:0] chain_pc     [NUM_STAGES+1];
    logic                          chain_legal  [NUM_STAGES+1];
    logic                          chain_bubble [NUM_STAGES+1];
    logic [NUM_STAGES-1:0]         prev_stall;

    fetch_capture u_capture (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_i),
        .fetch_inst_i  (fetch_inst_i),
        .fetch_pc_i    (fetch_pc_i),
        .stall_i       (stall_i[0]),
        .flush_i       (flush_i[0]),
        .inst_o        (chain_inst[0]),
        .pc_o          (chain_pc[0]),
        .legal_o       (chain_legal[0]),
        .bubble_o      (chain_bubble[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        // stage 0 shares the capture stall
        if (k == 0) begin : g_first
            assign prev_stall[k] = stall_i[0];
        end else begin : g_rest
            assign prev_stall[k] = stall_i[k-1];
        end

        pipe_stage u_stage (
            .clk          (clk),
            .rst          (rst),
            .stall_i      (stall_i[k]),
            .prev_stall_i (prev_stall[k]),
            .flush_i      (flush_i[k]),
            .inst_i       (chain_inst[k]),
            .pc_i         (chain_pc[k]),
            .legal_i      (chain_legal[k]),
            .bubble_i     (chain_bubble[k]),
            .inst_o       (chain_inst[k+1]),
            .pc_o         (chain_pc[k+1]),
            .legal_o      (chain_legal[k+1]),
            .bubble_o     (chain_bubble[k+1])
        );
    end

    retire_check u_retire (
        .clk              (clk),
        .rst              (rst),
        .inst_i           (chain_inst[NUM_STAGES]),
        .pc_i             (chain_pc[NUM_STAGES]),
        .legal_i          (chain_legal[NUM_STAGES]),
        .bubble_i         (chain_bubble[NUM_STAGES]),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_inst_o    (retire_inst_o),
        .retire_illegal_o (retire_illegal_o),
        .gold_valid_o     (gold_valid_o),
        .gold_result_o    (gold_result_o),
        .pc_error_o       (pc_error_o)
    );

endmodule

// File: source/rv_trace_pkg.sv
package rv_trace_pkg;

    // data, address and instruction widths
    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // addi x0, x0, 0
    localparam logic [ILEN-1:0] NOP_INST = 32'h0000_0013;
    localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0200;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_t;

    // load widths
    localparam logic [2:0] F3_LB = 3'b000;
    localparam logic [2:0] F3_LH = 3'b001;
    localparam logic [2:0] F3_LW = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store widths
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // branch conditions, 010 and 011 are reserved
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // misc-mem
    localparam logic [2:0] F3_FENCE = 3'b000;
    localparam logic [2:0] F3_FENCE_I = 3'b001;

    // op / op-imm codes that constrain funct7
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR = 3'b101;

    // funct7 for the base op and for sub/sra/srai
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // one instruction word seen through the i, j and u formats
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
        struct packed {
            logic [19:0] uimm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } rv_word_u;

endpackage

// File: sources.f
+incdir+sim
source/rv_trace_pkg.sv
source/fetch_capture.sv
source/pipe_stage.sv
source/retire_check.sv
source/rv_pipe_tracker.sv
sim/tb_rv_pipe_tracker.sv
